// ==== dv/datapathTb.sv ====
`timescale 1ns/1ns

module datapathTb;

    import datapathPkg::*;

    localparam int cycleLimit = 2000;  // About 150 operations of up to eight cycles each

    logic                 Clock;
    logic                 rstN;
    logic                 pcOut;
    logic                 mdrOut;
    logic                 zHighOut;
    logic                 zLowOut;
    logic                 hiOut;
    logic                 loOut;
    logic [numRegs-1:0]   regOut;
    logic                 pcEnable;
    logic                 incPc;
    logic                 irEnable;
    logic                 marEnable;
    logic                 mdrEnable;
    logic                 read;
    logic                 yEnable;
    logic                 zEnable;
    logic                 hiEnable;
    logic                 loEnable;
    logic [numRegs-1:0]   regIn;
    aluOpcode             opcode;
    logic [wordWidth-1:0] mdatain;
    logic [wordWidth-1:0] busData;
    logic [wordWidth-1:0] marAddress;
    logic [wordWidth-1:0] irValue;

    logic [wordWidth-1:0] model [numRegs];  // Mirror of the general registers
    aluOpcode             opList [11];
    int                   cycleCount;
    int                   errorCount;
    int                   checkCount;

    // Pending checks, filled by the step tasks and drained by the compare process
    string                nameQ [$];
    logic [wordWidth-1:0] expQ [$];
    logic [wordWidth-1:0] actQ [$];
    time                  timeQ [$];
    string                checkName;
    logic [wordWidth-1:0] checkExpected;
    logic [wordWidth-1:0] checkActual;
    time                  checkTime;

    datapath uut (.*);

    always #2 Clock = ~Clock;

    // Expected 64-bit ALU result
    function automatic logic [2*wordWidth-1:0] aluModel(input aluOpcode op,
                                                        input logic [wordWidth-1:0] a,
                                                        input logic [wordWidth-1:0] b);
        logic signed [2*wordWidth-1:0] sa;
        logic signed [2*wordWidth-1:0] sb;
        logic [wordWidth-1:0]          w;
        int                            n;
        sa = $signed(a);
        sb = $signed(b);
        n = b[4:0];
        case (op)
            opAdd:   w = a + b;
            opSub:   w = a - b;
            opShr:   w = a >> n;
            opShl:   w = a << n;
            opRor:   w = (a >> n) | (a << (wordWidth - n));  // Shift by 32 yields zero
            opRol:   w = (a << n) | (a >> (wordWidth - n));
            opAnd:   w = a & b;
            opOr:    w = a | b;
            opNeg:   w = ~b + 1;
            opNot:   w = ~b;
            default: w = '0;
        endcase
        if (op == opMul) return sa * sb;
        return {{wordWidth{1'b0}}, w};
    endfunction

    task automatic clearStrobes;
        pcOut = 1'b0;
        mdrOut = 1'b0;
        zHighOut = 1'b0;
        zLowOut = 1'b0;
        hiOut = 1'b0;
        loOut = 1'b0;
        regOut = '0;
        pcEnable = 1'b0;
        incPc = 1'b0;
        irEnable = 1'b0;
        marEnable = 1'b0;
        mdrEnable = 1'b0;
        read = 1'b0;
        yEnable = 1'b0;
        zEnable = 1'b0;
        hiEnable = 1'b0;
        loEnable = 1'b0;
        regIn = '0;
    endtask

    task automatic recordCheck(input string name, input logic [wordWidth-1:0] expected,
                               input logic [wordWidth-1:0] actual);
        nameQ.push_back(name);
        expQ.push_back(expected);
        actQ.push_back(actual);
        timeQ.push_back($time);
    endtask

    // Each step sets its strobes on a falling edge and holds them through the rising edge
    task automatic nextStep;
        @(negedge Clock);
        clearStrobes();
    endtask

    task automatic loadRegister(input int k, input logic [wordWidth-1:0] value);
        nextStep();
        mdatain = value;
        mdrEnable = 1'b1;
        read = 1'b1;
        nextStep();
        mdrOut = 1'b1;
        regIn[k] = 1'b1;
        model[k] = value;
    endtask

    task automatic readRegister(input int k);
        nextStep();
        regOut[k] = 1'b1;
        #1 recordCheck($sformatf("R%0d", k), model[k], busData);
    endtask

    task automatic runAlu(input aluOpcode op, input int a, input int b, input int d);
        logic [2*wordWidth-1:0] expected;
        expected = aluModel(op, model[a], model[b]);
        nextStep();
        regOut[a] = 1'b1;
        yEnable = 1'b1;
        nextStep();
        regOut[b] = 1'b1;
        zEnable = 1'b1;
        opcode = op;
        nextStep();
        zLowOut = 1'b1;
        regIn[d] = 1'b1;
        model[d] = expected[wordWidth-1:0];
        readRegister(d);
    endtask

    task automatic multiplyToHiLo(input int a, input int b);
        logic [2*wordWidth-1:0] expected;
        expected = aluModel(opMul, model[a], model[b]);
        nextStep();
        regOut[a] = 1'b1;
        yEnable = 1'b1;
        nextStep();
        regOut[b] = 1'b1;
        zEnable = 1'b1;
        opcode = opMul;
        nextStep();
        zHighOut = 1'b1;
        hiEnable = 1'b1;
        nextStep();
        zLowOut = 1'b1;
        loEnable = 1'b1;
        nextStep();
        hiOut = 1'b1;
        #1 recordCheck("HI", expected[2*wordWidth-1:wordWidth], busData);
        nextStep();
        loOut = 1'b1;
        #1 recordCheck("LO", expected[wordWidth-1:0], busData);
    endtask

    task automatic fetch(input int index, input logic [wordWidth-1:0] word);
        nextStep();
        pcOut = 1'b1;
        marEnable = 1'b1;
        pcEnable = 1'b1;
        incPc = 1'b1;
        @(negedge Clock);
        recordCheck("marAddress", index, marAddress);
        clearStrobes();
        mdatain = word;
        mdrEnable = 1'b1;
        read = 1'b1;
        nextStep();
        mdrOut = 1'b1;
        irEnable = 1'b1;
        @(negedge Clock);
        recordCheck("irValue", word, irValue);
        clearStrobes();
    endtask

    // Compare process
    always @(posedge Clock) begin
        while (expQ.size() > 0) begin
            checkName = nameQ.pop_front();
            checkExpected = expQ.pop_front();
            checkActual = actQ.pop_front();
            checkTime = timeQ.pop_front();
            checkCount++;
            if (checkActual !== checkExpected) begin
                errorCount++;
                $display("Mismatch at %0t ns: %s expected %h, actual %h",
                         checkTime, checkName, checkExpected, checkActual);
            end
        end
    end

    always @(posedge Clock) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, the tests did not finish, %0d errors",
                     cycleCount, errorCount);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        opList = '{opAdd, opSub, opShr, opShl, opRor, opRol, opAnd, opOr, opMul, opNeg, opNot};
        void'($urandom(32'h7218_76de));
        Clock = 1'b0;
        rstN = 1'b0;
        opcode = opAdd;
        mdatain = '0;
        cycleCount = 0;
        errorCount = 0;
        checkCount = 0;
        clearStrobes();
        for (int k = 0; k < numRegs; k++) model[k] = '0;
        repeat (8) @(posedge Clock);
        @(negedge Clock);
        rstN = 1'b1;

        // Everything reads zero after reset
        for (int k = 0; k < numRegs; k++) readRegister(k);
        nextStep();
        #1 recordCheck("busData", '0, busData);
        recordCheck("marAddress", '0, marAddress);
        recordCheck("irValue", '0, irValue);

        // Random words through MDR, with a few fixed corner values
        for (int k = 0; k < numRegs; k++) begin
            if (k == 2) loadRegister(k, 32'h0000_0018);
            else if (k == 4) loadRegister(k, 32'hFFFF_FFFF);
            else if (k == 5) loadRegister(k, 32'h0000_0000);
            else loadRegister(k, $urandom);
        end
        for (int k = 0; k < numRegs; k++) readRegister(k);

        runAlu(opShl, 2, 3, 1);  // R1 = R2 << R3
        repeat (99) begin
            runAlu(opList[$urandom_range(0, 10)], $urandom_range(0, numRegs - 1),
                   $urandom_range(0, numRegs - 1), $urandom_range(0, numRegs - 1));
        end

        multiplyToHiLo($urandom_range(0, numRegs - 1), $urandom_range(0, numRegs - 1));
        loadRegister(4, 32'hFFFF_FFFF);
        loadRegister(2, 32'h0000_0018);
        multiplyToHiLo(4, 2);  // Negative times positive

        for (int i = 0; i < 3; i++) fetch(i, 32'h3091_8000 + i * 32'h0000_1000);

        nextStep();
        repeat (2) @(posedge Clock);
        $display("Run complete: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
verilog/datapathPkg.sv
verilog/registerFile.sv
verilog/busMux.sv
verilog/alu.sv
verilog/specialRegisters.sv
verilog/datapath.sv
dv/datapathTb.sv

// ==== verilog/alu.sv ====
`timescale 1ns/1ns

module alu (
    input  datapathPkg::aluOpcode                 opcode,
    input  logic [datapathPkg::wordWidth-1:0]     operandA,   // From Y
    input  logic [datapathPkg::wordWidth-1:0]     operandB,   // From the bus
    output logic [2*datapathPkg::wordWidth-1:0]   result
);

    import datapathPkg::*;

    logic [4:0]                  shiftCount;
    logic [2*wordWidth-1:0]      doubled;
    logic [2*wordWidth-1:0]      rotRight;
    logic [2*wordWidth-1:0]      rotLeft;
    logic signed [2*wordWidth-1:0] product;
    logic [wordWidth-1:0]        lowWord;

    assign shiftCount = operandB[4:0];  // Only the low five bits count

    // Rotates come from a doubled copy of A
    assign doubled  = {operandA, operandA};
    assign rotRight = doubled >> shiftCount;
    assign rotLeft  = doubled << shiftCount;

    // Both operands sign extended to the full product width
    assign product = $signed(operandA) * $signed(operandB);

    // Single-word results
    always_comb begin
        case (opcode)
            opAdd:   lowWord = operandA + operandB;     // Wraps modulo 2^32
            opSub:   lowWord = operandA - operandB;
            opShr:   lowWord = operandA >> shiftCount;  // Logical, zero fill
            opShl:   lowWord = operandA << shiftCount;
            opRor:   lowWord = rotRight[wordWidth-1:0];
            opRol:   lowWord = rotLeft[2*wordWidth-1:wordWidth];
            opAnd:   lowWord = operandA & operandB;
            opOr:    lowWord = operandA | operandB;
            opNeg:   lowWord = -operandB;               // B only
            opNot:   lowWord = ~operandB;
            default: lowWord = '0;
        endcase
    end

    // Multiply fills both halves, everything else lands in the low word
    always_comb begin
        if (opcode == opMul) begin
            result = product;
        end else begin
            result = {{wordWidth{1'b0}}, lowWord};
        end
    end

endmodule

// ==== verilog/busMux.sv ====
`timescale 1ns/1ns

module busMux (
    input  logic                                  Clock,       // Only samples the assertion
    input  logic [datapathPkg::numRegs-1:0]       regOut,
    input  logic                                  pcOut,
    input  logic                                  mdrOut,
    input  logic                                  zHighOut,
    input  logic                                  zLowOut,
    input  logic                                  hiOut,
    input  logic                                  loOut,
    input  logic [datapathPkg::wordWidth-1:0]     generalData,
    input  logic [datapathPkg::wordWidth-1:0]     pcValue,
    input  logic [datapathPkg::wordWidth-1:0]     mdrValue,
    input  logic [2*datapathPkg::wordWidth-1:0]   zValue,
    input  logic [datapathPkg::wordWidth-1:0]     hiValue,
    input  logic [datapathPkg::wordWidth-1:0]     loValue,
    output logic [datapathPkg::wordWidth-1:0]     busData
);

    import datapathPkg::*;

    busSource         source;
    logic [numRegs+5:0] allStrobes;

    assign allStrobes = {regOut, pcOut, mdrOut, zHighOut, zLowOut, hiOut, loOut};

    // Strobes to a source code
    always_comb begin
        if (|regOut)       source = srcGeneral;
        else if (pcOut)    source = srcPc;
        else if (mdrOut)   source = srcMdr;
        else if (zHighOut) source = srcZHigh;
        else if (zLowOut)  source = srcZLow;
        else if (hiOut)    source = srcHi;
        else if (loOut)    source = srcLo;
        else               source = srcNone;
    end

    always_comb begin
        case (source)
            srcGeneral: busData = generalData;
            srcPc:      busData = pcValue;
            srcMdr:     busData = mdrValue;
            srcZHigh:   busData = zValue[2*wordWidth-1:wordWidth];  // Upper product word
            srcZLow:    busData = zValue[wordWidth-1:0];
            srcHi:      busData = hiValue;
            srcLo:      busData = loValue;
            default:    busData = '0;                               // Idle bus reads zero
        endcase
    end

    // The control steps across both register blocks must never fight over the bus
    busOneDriver: assert property (@(posedge Clock) $onehot0(allStrobes))
        else $error("Two bus drivers at once, strobes %b", allStrobes);

endmodule

// ==== verilog/datapath.sv ====
`timescale 1ns/1ns

module datapath (
    input  logic                                Clock,
    input  logic                                rstN,
    // Bus drivers
    input  logic                                pcOut,
    input  logic                                mdrOut,
    input  logic                                zHighOut,
    input  logic                                zLowOut,
    input  logic                                hiOut,
    input  logic                                loOut,
    input  logic [datapathPkg::numRegs-1:0]     regOut,
    // Load strobes
    input  logic                                pcEnable,
    input  logic                                incPc,
    input  logic                                irEnable,
    input  logic                                marEnable,
    input  logic                                mdrEnable,
    input  logic                                read,
    input  logic                                yEnable,
    input  logic                                zEnable,
    input  logic                                hiEnable,
    input  logic                                loEnable,
    input  logic [datapathPkg::numRegs-1:0]     regIn,
    input  datapathPkg::aluOpcode               opcode,
    input  logic [datapathPkg::wordWidth-1:0]   mdatain,   // Memory read data
    output logic [datapathPkg::wordWidth-1:0]   busData,
    output logic [datapathPkg::wordWidth-1:0]   marAddress,
    output logic [datapathPkg::wordWidth-1:0]   irValue
);

    import datapathPkg::*;

    logic [wordWidth-1:0]   generalData;
    logic [wordWidth-1:0]   pcValue;
    logic [wordWidth-1:0]   mdrValue;
    logic [wordWidth-1:0]   yValue;
    logic [wordWidth-1:0]   hiValue;
    logic [wordWidth-1:0]   loValue;
    logic [2*wordWidth-1:0] zValue;
    logic [2*wordWidth-1:0] aluResult;

    registerFile generalRegs (
        .Clock    (Clock),
        .rstN     (rstN),
        .regIn    (regIn),
        .regOut   (regOut),
        .busData  (busData),
        .readData (generalData)
    );

    specialRegisters specialRegs (
        .Clock      (Clock),
        .rstN       (rstN),
        .busData    (busData),
        .mdatain    (mdatain),
        .aluResult  (aluResult),
        .pcEnable   (pcEnable),
        .incPc      (incPc),
        .irEnable   (irEnable),
        .marEnable  (marEnable),
        .mdrEnable  (mdrEnable),
        .read       (read),
        .yEnable    (yEnable),
        .zEnable    (zEnable),
        .hiEnable   (hiEnable),
        .loEnable   (loEnable),
        .pcValue    (pcValue),
        .irValue    (irValue),
        .marAddress (marAddress),
        .mdrValue   (mdrValue),
        .yValue     (yValue),
        .zValue     (zValue),
        .hiValue    (hiValue),
        .loValue    (loValue)
    );

    busMux internalBus (
        .Clock       (Clock),
        .regOut      (regOut),
        .pcOut       (pcOut),
        .mdrOut      (mdrOut),
        .zHighOut    (zHighOut),
        .zLowOut     (zLowOut),
        .hiOut       (hiOut),
        .loOut       (loOut),
        .generalData (generalData),
        .pcValue     (pcValue),
        .mdrValue    (mdrValue),
        .zValue      (zValue),
        .hiValue     (hiValue),
        .loValue     (loValue),
        .busData     (busData)
    );

    // Y is the held operand, the bus the live one
    alu mainAlu (
        .opcode   (opcode),
        .operandA (yValue),
        .operandB (busData),
        .result   (aluResult)
    );

endmodule

// ==== verilog/datapathPkg.sv ====
package datapathPkg;

    // Datapath geometry
    localparam int wordWidth     = 32;  // Bus and register width
    localparam int numRegs       = 16;  // General registers R0..R15
    localparam int regIndexWidth = 4;   // Enough to index numRegs

    // ALU operation codes, numbered as in the original control steps
    typedef enum logic [4:0] {
        opAdd = 5'd3,
        opSub = 5'd4,
        opShr = 5'd5,
        opShl = 5'd6,
        opRor = 5'd7,
        opRol = 5'd8,
        opAnd = 5'd9,
        opOr  = 5'd10,
        opMul = 5'd15,
        opNeg = 5'd17,
        opNot = 5'd18
    } aluOpcode;

    // Which block currently drives the internal bus
    typedef enum logic [2:0] {
        srcNone,
        srcGeneral,
        srcPc,
        srcMdr,
        srcZHigh,
        srcZLow,
        srcHi,
        srcLo
    } busSource;

endpackage

// ==== verilog/registerFile.sv ====
`timescale 1ns/1ns

module registerFile (
    input  logic                                Clock,
    input  logic                                rstN,
    input  logic [datapathPkg::numRegs-1:0]     regIn,     // Load strobes, one per register
    input  logic [datapathPkg::numRegs-1:0]     regOut,    // One-hot read select
    input  logic [datapathPkg::wordWidth-1:0]   busData,
    output logic [datapathPkg::wordWidth-1:0]   readData
);

    import datapathPkg::*;

    logic [wordWidth-1:0]     regs [numRegs];
    logic [regIndexWidth-1:0] selIndex;
    logic                     selValid;

    // Every register with its strobe set takes the bus word
    always_ff @(posedge Clock) begin
        for (int k = 0; k < numRegs; k++) begin
            if (!rstN) begin
                regs[k] <= '0;
            end else if (regIn[k]) begin
                regs[k] <= busData;
            end
        end
    end

    // One-hot select to an index
    always_comb begin
        selIndex = '0;
        selValid = 1'b0;
        for (int k = 0; k < numRegs; k++) begin
            if (regOut[k]) begin
                selIndex = regIndexWidth'(k);
                selValid = 1'b1;
            end
        end
    end

    assign readData = selValid ? regs[selIndex] : '0;  // Zero when nothing selected

endmodule

// ==== verilog/specialRegisters.sv ====
`timescale 1ns/1ns

module specialRegisters (
    input  logic                                  Clock,
    input  logic                                  rstN,
    input  logic [datapathPkg::wordWidth-1:0]     busData,
    input  logic [datapathPkg::wordWidth-1:0]     mdatain,
    input  logic [2*datapathPkg::wordWidth-1:0]   aluResult,
    input  logic                                  pcEnable,
    input  logic                                  incPc,
    input  logic                                  irEnable,
    input  logic                                  marEnable,
    input  logic                                  mdrEnable,
    input  logic                                  read,
    input  logic                                  yEnable,
    input  logic                                  zEnable,
    input  logic                                  hiEnable,
    input  logic                                  loEnable,
    output logic [datapathPkg::wordWidth-1:0]     pcValue,
    output logic [datapathPkg::wordWidth-1:0]     irValue,
    output logic [datapathPkg::wordWidth-1:0]     marAddress,
    output logic [datapathPkg::wordWidth-1:0]     mdrValue,
    output logic [datapathPkg::wordWidth-1:0]     yValue,
    output logic [2*datapathPkg::wordWidth-1:0]   zValue,
    output logic [datapathPkg::wordWidth-1:0]     hiValue,
    output logic [datapathPkg::wordWidth-1:0]     loValue
);

    import datapathPkg::*;

    // PC either steps by one or takes the bus
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            pcValue <= '0;
        end else if (pcEnable) begin
            pcValue <= incPc ? pcValue + wordWidth'(1) : busData;
        end
    end

    // MDR source depends on read
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            mdrValue <= '0;
        end else if (mdrEnable) begin
            mdrValue <= read ? mdatain : busData;  // Memory word or bus
        end
    end

    // The plain bus-loaded registers
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            irValue    <= '0;
            marAddress <= '0;
            yValue     <= '0;
            hiValue    <= '0;
            loValue    <= '0;
        end else begin
            if (irEnable)  irValue    <= busData;
            if (marEnable) marAddress <= busData;
            if (yEnable)   yValue     <= busData;
            if (hiEnable)  hiValue    <= busData;  // Filled from ZHigh by the control steps
            if (loEnable)  loValue    <= busData;
        end
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            zValue <= '0;
        end else if (zEnable) begin
            zValue <= aluResult;  // Y op bus
        end
    end

    // An increment only means something together with the PC load
    incPcNeedsEnable: assert property (@(posedge Clock) disable iff (!rstN) incPc |-> pcEnable)
        else $error("incPc high without pcEnable");

endmodule
